//--- sources.f
+incdir+.
heap_pkg.sv
heap_bram.sv
heap_alloc.sv
heap_top.sv
tb_heap.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the heap unit testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_heap \
    -f sources.f -Mdir obj_dir -o sim_heap \
    || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/sim_heap)" \
    || { echo "$sim_out"; echo "simulation aborted"; exit 1; }
echo "$sim_out"

echo "$sim_out" | grep -qx "Test OK" && exit 0 || exit 1

//--- tb_heap.sv
// heap unit testbench, directed alloc/free/read/write tests against a free-list model
`timescale 1ns/1ns
`include "heap_params.svh"

module tb_heap import heap_pkg::*; ();

    localparam int TIMEOUT_CYCLES = 2000;  // tests need about 700

    logic      clk = 1'b0;
    logic      reset;
    ptr_req_t  ptr_req;
    mem_req_t  mem_req;
    heap_rsp_t rsp;
    heap_cnt_t free_cnt;

    // reference model
    heap_word_t model_free[$];                  // free list, back is the head
    int         model_top;                      // next never-used cell
    logic       model_err;                      // expected sticky error
    heap_word_t model_mem [0:`HEAP_DEPTH-1];    // expected cell contents

    int errors = 0;
    int cycles = 0;
    int seed   = 77645;

    heap_top u_dut (
        .i_clk      (clk),
        .i_reset    (reset),
        .i_ptr_req  (ptr_req),
        .i_mem_req  (mem_req),
        .o_rsp      (rsp),
        .o_free_cnt (free_cnt)
    );

    always #50 clk = ~clk;  // 100 ns period

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Test FAILED");
            $finish;
        end
    end

    // heap pointer of a cell, mutable+volatile tags
    function automatic heap_word_t cell_ptr(input int idx);
        return 16'h5000 | 16'(idx);
    endfunction

    // upper nibble 5 and zero middle nibble
    function automatic logic valid_ptr(input heap_word_t w);
        return (w[15:12] == 4'h5) && (w[11:8] == 4'h0);
    endfunction

    task automatic rand_word(output heap_word_t w);
        int r;
        r = $random(seed);
        w = r[15:0];
    endtask

    task automatic idle_inputs();
        ptr_req = '0;
        mem_req = '0;
    endtask

    task automatic check_word(input string what, input heap_word_t got, input heap_word_t exp);
        assert (got === exp) else begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // error flag, pointer output and free count after any request
    task automatic check_status(input string what, input heap_word_t exp_addr);
        check_word({what, " addr"}, rsp.addr, exp_addr);
        assert (rsp.err === model_err) else begin
            errors++;
            $display("MISMATCH at %0t: %s err got %b expected %b",
                     $time, what, rsp.err, model_err);
        end
        assert (int'(free_cnt) == model_free.size()) else begin
            errors++;
            $display("MISMATCH at %0t: %s free count got %0d expected %0d",
                     $time, what, free_cnt, model_free.size());
        end
    endtask

    task automatic do_reset();
        reset = 1'b1;
        idle_inputs();
        repeat (5) @(negedge clk);
        reset = 1'b0;
        model_free.delete();  // RAM contents survive reset
        model_top = 0;
        model_err = 1'b0;
        check_status("after reset", UNDEF_W);
    endtask

    task automatic alloc_cell(input heap_word_t data, output heap_word_t got);
        heap_word_t exp;
        exp = UNDEF_W;
        ptr_req.alloc = 1'b1;
        ptr_req.data  = data;
        @(negedge clk);
        idle_inputs();
        if (!model_err) begin
            if (model_free.size() > 0) begin
                exp = model_free.pop_back();  // LIFO
            end else if (model_top < `HEAP_DEPTH) begin
                exp = cell_ptr(model_top);
                model_top++;
            end else begin
                model_err = 1'b1;  // out of memory
            end
        end
        if (exp != UNDEF_W) begin
            model_mem[exp[7:0]] = data;
        end
        check_status("alloc", exp);
        got = rsp.addr;
    endtask

    task automatic free_cell(input heap_word_t addr);
        ptr_req.free = 1'b1;
        ptr_req.addr = addr;
        @(negedge clk);
        idle_inputs();
        if (!model_err) begin
            if (valid_ptr(addr)) begin
                model_free.push_back(addr);
            end else begin
                model_err = 1'b1;
            end
        end
        check_status("free", UNDEF_W);
    endtask

    // freed cell goes straight back out with new data
    task automatic alloc_free(input heap_word_t data, input heap_word_t addr);
        heap_word_t exp;
        exp = UNDEF_W;
        ptr_req.alloc = 1'b1;
        ptr_req.free  = 1'b1;
        ptr_req.data  = data;
        ptr_req.addr  = addr;
        @(negedge clk);
        idle_inputs();
        if (!model_err) begin
            if (valid_ptr(addr)) begin
                exp = addr;
                model_mem[addr[7:0]] = data;
            end else begin
                model_err = 1'b1;
            end
        end
        check_status("alloc+free", exp);
    endtask

    task automatic write_cell(input heap_word_t addr, input heap_word_t data);
        mem_req.wr    = 1'b1;
        mem_req.waddr = addr;
        mem_req.wdata = data;
        @(negedge clk);
        idle_inputs();
        if (!model_err) begin
            if (valid_ptr(addr)) begin
                model_mem[addr[7:0]] = data;
            end else begin
                model_err = 1'b1;  // not a heap pointer
            end
        end
        check_status("write", UNDEF_W);
    endtask

    task automatic read_cell(input heap_word_t addr);
        mem_req.rd    = 1'b1;
        mem_req.raddr = addr;
        @(negedge clk);
        idle_inputs();
        check_word("read data", rsp.rdata, model_mem[addr[7:0]]);
        check_status("read", UNDEF_W);
    endtask

    // same-cycle write and read, read sees the old word
    task automatic write_read(input heap_word_t addr, input heap_word_t data);
        heap_word_t old;
        old = model_mem[addr[7:0]];
        mem_req.wr    = 1'b1;
        mem_req.rd    = 1'b1;
        mem_req.waddr = addr;
        mem_req.wdata = data;
        mem_req.raddr = addr;
        @(negedge clk);
        idle_inputs();
        model_mem[addr[7:0]] = data;
        check_word("write+read old data", rsp.rdata, old);
        check_status("write+read", UNDEF_W);
    endtask

    task automatic test_reset_alloc();
        heap_word_t d;
        heap_word_t p;
        do_reset();
        for (int i = 0; i < 3; i++) begin
            rand_word(d);
            alloc_cell(d, p);
            check_word("first allocs", p, 16'h5000 + 16'(i));
        end
        for (int i = 0; i < 3; i++) begin
            read_cell(cell_ptr(i));  // initial data
        end
    endtask

    task automatic test_write_read();
        heap_word_t d;
        for (int i = 0; i < 3; i++) begin
            rand_word(d);
            write_cell(cell_ptr(i), d);
        end
        for (int i = 2; i >= 0; i--) begin
            read_cell(cell_ptr(i));
        end
        rand_word(d);
        write_read(16'h5001, d);
        read_cell(16'h5001);  // new word now
        @(negedge clk);
        check_word("read data held", rsp.rdata, model_mem[8'h01]);  // idle keeps last read
    endtask

    task automatic test_free_lifo();
        heap_word_t d;
        heap_word_t p;
        free_cell(16'h5001);
        @(negedge clk);
        free_cell(16'h5000);
        check_word("free count", 16'(free_cnt), 16'd2);
        @(negedge clk);
        rand_word(d);
        alloc_cell(d, p);
        check_word("lifo first", p, 16'h5000);
        @(negedge clk);
        rand_word(d);
        alloc_cell(d, p);
        check_word("lifo second", p, 16'h5001);
        rand_word(d);
        alloc_cell(d, p);
        check_word("top cell", p, 16'h5003);
        // back-to-back frees and allocs, successor fetch path
        free_cell(16'h5003);
        free_cell(16'h5000);
        free_cell(16'h5002);
        for (int i = 0; i < 4; i++) begin
            rand_word(d);
            alloc_cell(d, p);
        end
        for (int i = 0; i < 5; i++) begin
            read_cell(cell_ptr(i));
        end
    endtask

    task automatic test_alloc_free();
        heap_word_t d;
        heap_word_t p;
        free_cell(16'h5000);
        rand_word(d);
        alloc_free(d, 16'h5001);  // count stays at 1
        read_cell(16'h5001);
        rand_word(d);
        alloc_cell(d, p);
        read_cell(16'h5000);
    endtask

    task automatic test_out_of_memory();
        heap_word_t d;
        heap_word_t p;
        do_reset();
        for (int i = 0; i < `HEAP_DEPTH; i++) begin
            rand_word(d);
            alloc_cell(d, p);
        end
        check_word("last cell", p, 16'h50ff);
        alloc_cell(16'h1234, p);  // 257th
        assert (rsp.err === 1'b1) else begin
            errors++;
            $display("out of memory did not raise o_err at %0t", $time);
        end
        alloc_cell(16'h4321, p);
        free_cell(16'h5010);
        write_cell(16'h5011, 16'hbeef);
        alloc_free(16'h0, 16'h5012);
        do_reset();
        read_cell(16'h5011);  // halted writes left these cells alone
        read_cell(16'h5012);
    endtask

    task automatic test_errors();
        do_reset();
        ptr_req.alloc = 1'b1;  // both ports in one cycle
        mem_req.rd    = 1'b1;
        mem_req.raddr = 16'h5000;
        @(negedge clk);
        idle_inputs();
        model_err = 1'b1;
        check_status("port conflict", UNDEF_W);
        do_reset();
        write_cell(16'h8005, 16'h00aa);  // fixnum, not a heap pointer
        assert (rsp.err === 1'b1) else begin
            errors++;
            $display("write to non-heap word did not raise o_err at %0t", $time);
        end
        do_reset();
    endtask

    initial begin
        reset = 1'b1;
        idle_inputs();
        model_err = 1'b0;
        model_top = 0;
        test_reset_alloc();
        test_write_read();
        test_free_lifo();
        test_alloc_free();
        test_out_of_memory();
        test_errors();
        @(negedge clk);
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- heap_top.sv
// heap unit top, allocator controller driving the cell RAM behind struct ports
`timescale 1ns/1ns
`include "heap_params.svh"

module heap_top import heap_pkg::*; (
    input  logic      i_clk,
    input  logic      i_reset,
    input  ptr_req_t  i_ptr_req,   // alloc / free
    input  mem_req_t  i_mem_req,   // write / read
    output heap_rsp_t o_rsp,
    output heap_cnt_t o_free_cnt
);

    // allocator to RAM
    logic       wr_en;
    heap_idx_t  widx;
    heap_word_t wdata;
    logic       rd_en;
    heap_idx_t  ridx;
    heap_word_t rdata;   // registered data read
    logic       lk_en;
    heap_idx_t  lkidx;
    heap_word_t lkdata;  // registered link read

    heap_alloc u_alloc (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_ptr_req  (i_ptr_req),
        .i_mem_req  (i_mem_req),
        .o_rsp      (o_rsp),
        .o_free_cnt (o_free_cnt),
        .o_wr_en    (wr_en),
        .o_widx     (widx),
        .o_wdata    (wdata),
        .o_rd_en    (rd_en),
        .o_ridx     (ridx),
        .i_rdata    (rdata),
        .o_lk_en    (lk_en),
        .o_lkidx    (lkidx),
        .i_lkdata   (lkdata)
    );

    heap_bram u_bram (
        .i_clk    (i_clk),
        .i_wr_en  (wr_en),
        .i_widx   (widx),
        .i_wdata  (wdata),
        .i_rd_en  (rd_en),
        .i_ridx   (ridx),
        .o_rdata  (rdata),
        .i_lk_en  (lk_en),
        .i_lkidx  (lkidx),
        .o_lkdata (lkdata)
    );

endmodule

//--- heap_alloc.sv
// heap allocator, decodes pointer and memory requests, runs the free list and flags errors
`timescale 1ns/1ns
`include "heap_params.svh"

module heap_alloc import heap_pkg::*; (
    input  logic       i_clk,
    input  logic       i_reset,

    input  ptr_req_t   i_ptr_req,   // alloc / free strobes
    input  mem_req_t   i_mem_req,   // write / read strobes
    output heap_rsp_t  o_rsp,       // pointer, read word, error
    output heap_cnt_t  o_free_cnt,  // cells on the free list

    output logic       o_wr_en,     // RAM write port
    output heap_idx_t  o_widx,
    output heap_word_t o_wdata,

    output logic       o_rd_en,     // RAM data read port
    output heap_idx_t  o_ridx,
    input  heap_word_t i_rdata,

    output logic       o_lk_en,     // RAM link read port
    output heap_idx_t  o_lkidx,
    input  heap_word_t i_lkdata
);

    // control state
    logic       err_q;      // sticky error, halts the unit
    heap_word_t addr_q;     // pointer handed out last cycle
    heap_cnt_t  top_q;      // next never-used cell, msb = heap full
    heap_word_t head_q;     // free-list head, NIL when empty
    heap_word_t succ_q;     // cell after the head
    logic       lk_pend_q;  // successor still arriving from RAM
    heap_cnt_t  cnt_q;      // free-list length

    // request decode
    logic ptr_any;
    logic mem_any;
    logic ptr_op;
    logic mem_op;
    logic no_op;
    logic conflict;

    // checks
    logic list_empty;
    logic bad_free;
    logic bad_wr;
    logic bad_rd;
    logic oom;
    logic bad;
    logic go;

    // actions this cycle
    logic       pass;       // alloc+free, freed cell goes straight back out
    logic       pop;        // alloc from free-list head
    logic       grow;       // alloc from top
    logic       link;       // free, push onto list
    logic       mem_wr;
    logic       mem_rd;
    logic       lk_fetch;   // follow the new head's link
    heap_word_t succ_eff;   // current successor of the head

    assign ptr_any  = i_ptr_req.alloc || i_ptr_req.free;
    assign mem_any  = i_mem_req.wr || i_mem_req.rd;
    assign ptr_op   = ptr_any && !mem_any;
    assign mem_op   = mem_any && !ptr_any;
    assign no_op    = !ptr_any && !mem_any;
    assign conflict = ptr_any && mem_any;  // both ports in one cycle

    assign list_empty = (head_q == NIL_W);
    assign bad_free   = i_ptr_req.free && !is_heap_ptr(i_ptr_req.addr);
    assign bad_wr     = i_mem_req.wr && !is_heap_ptr(i_mem_req.waddr);
    assign bad_rd     = i_mem_req.rd && !is_heap_ptr(i_mem_req.raddr);
    assign oom        = i_ptr_req.alloc && !i_ptr_req.free && list_empty
                        && top_q[`HEAP_IDX_SZ];  // top past last cell
    assign bad        = conflict || bad_free || bad_wr || bad_rd || oom;
    assign go         = !err_q && !bad && !no_op;  // nothing moves once halted

    assign pass   = go && ptr_op && i_ptr_req.alloc && i_ptr_req.free;
    assign pop    = go && ptr_op && i_ptr_req.alloc && !i_ptr_req.free && !list_empty;
    assign grow   = go && ptr_op && i_ptr_req.alloc && !i_ptr_req.free && list_empty;
    assign link   = go && ptr_op && !i_ptr_req.alloc && i_ptr_req.free;
    assign mem_wr = go && mem_op && i_mem_req.wr;
    assign mem_rd = go && mem_op && i_mem_req.rd;

    assign succ_eff = lk_pend_q ? i_lkdata : succ_q;  // RAM output right after a pop
    assign lk_fetch = pop && (succ_eff != NIL_W);     // no fetch past the list end

    // RAM write port
    assign o_wr_en = pass || pop || grow || link || mem_wr;

    always_comb begin
        o_widx = ptr_idx(i_mem_req.waddr);  // memory port write
        if (pass || link) begin
            o_widx = ptr_idx(i_ptr_req.addr);
        end else if (pop) begin
            o_widx = ptr_idx(head_q);
        end else if (grow) begin
            o_widx = top_q[`HEAP_IDX_SZ-1:0];
        end
    end

    always_comb begin
        o_wdata = i_ptr_req.data;  // initial value of a new cell
        if (link) begin
            o_wdata = head_q;  // freed cell points at old head
        end else if (mem_wr) begin
            o_wdata = i_mem_req.wdata;
        end
    end

    // RAM read ports
    assign o_rd_en = mem_rd;
    assign o_ridx  = ptr_idx(i_mem_req.raddr);
    assign o_lk_en = lk_fetch;
    assign o_lkidx = ptr_idx(succ_eff);

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            err_q     <= 1'b0;
            addr_q    <= UNDEF_W;
            top_q     <= '0;  // top word is HEAP_BASE_W
            head_q    <= NIL_W;
            succ_q    <= NIL_W;
            lk_pend_q <= 1'b0;
            cnt_q     <= '0;
        end else begin
            addr_q    <= UNDEF_W;  // valid one cycle only
            lk_pend_q <= lk_fetch;
            succ_q    <= succ_eff;  // capture fetched link
            if (bad) begin
                err_q <= 1'b1;
            end
            if (pass) begin
                addr_q <= i_ptr_req.addr;  // count and list unchanged
            end
            if (pop) begin
                addr_q <= head_q;  // LIFO
                head_q <= succ_eff;
                cnt_q  <= cnt_q - 1'b1;
            end
            if (grow) begin
                addr_q <= idx_ptr(top_q[`HEAP_IDX_SZ-1:0]);
                top_q  <= top_q + 1'b1;  // msb set after the last cell
            end
            if (link) begin
                head_q <= i_ptr_req.addr;
                succ_q <= head_q;  // old head now follows
                cnt_q  <= cnt_q + 1'b1;
            end
        end
    end

    assign o_rsp      = '{addr: addr_q, rdata: i_rdata, err: err_q};
    assign o_free_cnt = cnt_q;

    // error only clears through reset
    a_err_sticky: assert property (
        @(posedge i_clk) $fell(err_q) |-> $past(i_reset)
    ) else $error("o_err fell without reset");

    // count and head agree on an empty list
    a_cnt_head: assert property (
        @(posedge i_clk) disable iff (i_reset) (cnt_q == '0) == (head_q == NIL_W)
    ) else $error("free count %0d disagrees with head %h", cnt_q, head_q);

endmodule

//--- heap_bram.sv
// heap cell RAM with one write port and registered data and link read ports
`timescale 1ns/1ns
`include "heap_params.svh"

module heap_bram import heap_pkg::*; (
    input  logic       i_clk,

    input  logic       i_wr_en,   // write strobe
    input  heap_idx_t  i_widx,    // write cell
    input  heap_word_t i_wdata,   // word written

    input  logic       i_rd_en,   // data read strobe
    input  heap_idx_t  i_ridx,    // data read cell
    output heap_word_t o_rdata,   // held until next data read

    input  logic       i_lk_en,   // link read strobe
    input  heap_idx_t  i_lkidx,   // free-list cell to follow
    output heap_word_t o_lkdata   // next free cell, one cycle later
);

    heap_word_t mem [0:`HEAP_DEPTH-1];  // cell storage, no reset

    always_ff @(posedge i_clk) begin
        if (i_wr_en) begin
            mem[i_widx] <= i_wdata;
        end
    end

    // reads see the word before a same-cycle write
    always_ff @(posedge i_clk) begin
        if (i_rd_en) begin
            o_rdata <= mem[i_ridx];
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_lk_en) begin
            o_lkdata <= mem[i_lkidx];  // free-list link fetch
        end
    end

endmodule

//--- heap_pkg.sv
// heap unit package with tagged word types, reserved constants and request/response structs
`include "heap_params.svh"

package heap_pkg;

    typedef logic [`HEAP_WORD_SZ-1:0] heap_word_t;  // tagged machine word
    typedef logic [`HEAP_IDX_SZ-1:0]  heap_idx_t;   // heap cell index
    typedef logic [`HEAP_CNT_SZ-1:0]  heap_cnt_t;   // index plus overflow bit

    // tag bits, top nibble
    localparam heap_word_t DIR_TAG  = 16'h8000;      // direct (fixnum) vs pointer
    localparam heap_word_t MUT_TAG  = 16'h4000;      // mutable vs rom
    localparam heap_word_t OPQ_TAG  = 16'h2000;      // opaque (cap) vs transparent
    localparam heap_word_t VLT_TAG  = 16'h1000;      // volatile vs reserved
    localparam heap_word_t TAG_MASK = DIR_TAG | MUT_TAG | OPQ_TAG | VLT_TAG;

    // reserved words
    localparam heap_word_t UNDEF_W     = 16'h0000;   // undefined value
    localparam heap_word_t NIL_W       = 16'h0001;   // empty list, free-list end
    localparam heap_word_t ZERO_W      = DIR_TAG;    // fixnum +0
    localparam heap_word_t HEAP_BASE_W = MUT_TAG | VLT_TAG;  // first heap cell, 0x5000

    // pointer port request
    typedef struct packed {
        logic       alloc;  // take a cell
        logic       free;   // give a cell back
        heap_word_t data;   // initial value of the new cell
        heap_word_t addr;   // cell to free
    } ptr_req_t;

    // memory port request
    typedef struct packed {
        logic       wr;     // write strobe
        logic       rd;     // read strobe
        heap_word_t waddr;
        heap_word_t wdata;
        heap_word_t raddr;
    } mem_req_t;

    // response, one cycle after the request
    typedef struct packed {
        heap_word_t addr;   // allocated pointer, else UNDEF
        heap_word_t rdata;  // last word read
        logic       err;    // sticky error
    } heap_rsp_t;

    // mutable+volatile tags, zero middle nibble
    function automatic logic is_heap_ptr(heap_word_t w);
        return ((w & TAG_MASK) == HEAP_BASE_W)
            && (w[`HEAP_WORD_SZ-`HEAP_TAG_SZ-1:`HEAP_IDX_SZ] == '0);
    endfunction

    function automatic heap_idx_t ptr_idx(heap_word_t w);
        return w[`HEAP_IDX_SZ-1:0];  // cell index of a pointer
    endfunction

    function automatic heap_word_t idx_ptr(heap_idx_t idx);
        return HEAP_BASE_W | {{(`HEAP_WORD_SZ-`HEAP_IDX_SZ){1'b0}}, idx};
    endfunction

endpackage

//--- heap_params.svh
// heap unit sizing macros for the tagged word, cell index and heap depth
`ifndef HEAP_PARAMS_SVH
`define HEAP_PARAMS_SVH

// word layout
`define HEAP_WORD_SZ 16                    // bits per tagged word
`define HEAP_TAG_SZ  4                     // tag nibble on top of the word

// cell addressing
`define HEAP_IDX_SZ  8                     // bits of cell index
`define HEAP_DEPTH   (1 << `HEAP_IDX_SZ)   // cells in the heap, 256

// counters that must hold a full heap
`define HEAP_CNT_SZ  (`HEAP_IDX_SZ + 1)    // extra bit for overflow

`endif
